// File: verilog/exec_macros.svh
/*
 * Execute stage width macros
 * - data and address width
 * - shift amount width
 * - link increments for full and compressed instructions
 */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// ====================
// datapath widths
// ====================
`define XLEN     32    // register and address width
`define SHAMT_W  5     // log2 of XLEN

// ====================
// instruction lengths
// ====================
`define INSN_LEN_FULL  4    // 32-bit encoding
`define INSN_LEN_COMP  2    // RVC encoding

`endif

// File: verilog/rv_isa_pkg.sv
/*
 * RV32I types seen by the execute stage
 * - register word and shift amount
 * - execute opcode enum
 */
`include "exec_macros.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0]    word_t;     // one x[] register value
    typedef logic [`SHAMT_W-1:0] shamt_t;    // shift distance

    // one code per execute operation with a single OP_MEM for loads and stores
    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_SUB   = 5'd1,
        OP_SLL   = 5'd2,
        OP_SLT   = 5'd3,
        OP_SLTU  = 5'd4,
        OP_XOR   = 5'd5,
        OP_SRL   = 5'd6,
        OP_SRA   = 5'd7,
        OP_OR    = 5'd8,
        OP_AND   = 5'd9,
        OP_LUI   = 5'd10,
        OP_AUIPC = 5'd11,
        OP_JAL   = 5'd12,
        OP_JALR  = 5'd13,
        OP_BEQ   = 5'd14,
        OP_BNE   = 5'd15,
        OP_BLT   = 5'd16,
        OP_BGE   = 5'd17,
        OP_BLTU  = 5'd18,
        OP_BGEU  = 5'd19,
        OP_MEM   = 5'd20     // address generation only
    } exec_op_e;

endpackage

// File: verilog/exec_pipe_pkg.sv
/*
 * Types passed between execute sub-units
 * - compare flags from the ALU to the branch unit
 */
package exec_pipe_pkg;

    // ====================
    // compare results
    // ====================
    // all three compare rs1 against operand b,
    // which is rs2 for every branch opcode
    typedef struct packed {
        logic eq;     // rs1 == b
        logic lt;     // signed rs1 < b
        logic ltu;    // unsigned rs1 < b
    } cmp_flags_t;

endpackage

// File: verilog/exec_if.sv
/*
 * Execute stage interfaces
 * - exec_req_if   decoded instruction into the units
 * - exec_ctrl_if  branch unit results toward retire
 */
interface exec_req_if;

    logic                 valid;      // live instruction this cycle
    rv_isa_pkg::exec_op_e op;
    logic                 use_imm;    // operand b is imm
    logic                 ins_c;      // compressed encoding
    rv_isa_pkg::word_t    rs1;
    rv_isa_pkg::word_t    rs2;
    rv_isa_pkg::word_t    imm;        // already sign extended
    rv_isa_pkg::word_t    pc;

    modport driver (output valid, op, use_imm, ins_c, rs1, rs2, imm, pc);
    modport alu    (input op, use_imm, rs1, rs2, imm, pc);
    modport branch (input op, ins_c, rs1, imm, pc);
    modport retire (input valid, op);

endinterface

interface exec_ctrl_if;

    logic              is_ctrl;    // branch or jump opcode
    logic              taken;      // redirect requested
    rv_isa_pkg::word_t target;
    rv_isa_pkg::word_t link;       // pc + insn length

    modport branch (output is_ctrl, taken, target, link);
    modport retire (input is_ctrl, taken, target, link);

endinterface

// File: verilog/exec_alu.sv
/*
 * Execute ALU
 * - shared adder for add, sub, auipc and memory address
 * - shifter, logic ops, lui pass-through
 * - signed and unsigned comparators with flags for the branch unit
 */
`include "exec_macros.svh"

module exec_alu (
    exec_req_if.alu                   req,
    output rv_isa_pkg::word_t         alu_result,
    output exec_pipe_pkg::cmp_flags_t flags
);

    rv_isa_pkg::word_t  op_b;
    rv_isa_pkg::word_t  add_a;
    rv_isa_pkg::word_t  add_b;
    logic               add_sub;
    rv_isa_pkg::word_t  add_sum;
    rv_isa_pkg::shamt_t shamt;
    rv_isa_pkg::word_t  shl;
    rv_isa_pkg::word_t  shr;
    logic               cmp_lt;
    logic               cmp_ltu;

    assign op_b = req.use_imm ? req.imm : req.rs2;

    // ====================
    // adder
    // ====================
    assign add_sub = (req.op == rv_isa_pkg::OP_SUB);
    assign add_a   = (req.op == rv_isa_pkg::OP_AUIPC) ? req.pc : req.rs1;

    // auipc and address generation always take the immediate
    always_comb begin
        if (req.op == rv_isa_pkg::OP_AUIPC || req.op == rv_isa_pkg::OP_MEM) begin
            add_b = req.imm;
        end else begin
            add_b = op_b;
        end
    end

    // subtract as a + ~b + 1
    assign add_sum = add_a + (add_sub ? ~add_b : add_b) + rv_isa_pkg::word_t'(add_sub);

    // ====================
    // shifter
    // ====================
    assign shamt = op_b[`SHAMT_W-1:0];    // low bits only
    assign shl   = req.rs1 << shamt;

    always_comb begin
        if (req.op == rv_isa_pkg::OP_SRA) begin
            shr = $signed(req.rs1) >>> shamt;    // sign fill
        end else begin
            shr = req.rs1 >> shamt;
        end
    end

    // ====================
    // comparators
    // ====================
    assign cmp_lt  = $signed(req.rs1) < $signed(op_b);
    assign cmp_ltu = req.rs1 < op_b;

    assign flags.eq  = (req.rs1 == op_b);
    assign flags.lt  = cmp_lt;
    assign flags.ltu = cmp_ltu;

    // ====================
    // result select
    // ====================
    always_comb begin
        case (req.op)
            rv_isa_pkg::OP_ADD,
            rv_isa_pkg::OP_SUB,
            rv_isa_pkg::OP_AUIPC,
            rv_isa_pkg::OP_MEM:   alu_result = add_sum;
            rv_isa_pkg::OP_SLL:   alu_result = shl;
            rv_isa_pkg::OP_SRL,
            rv_isa_pkg::OP_SRA:   alu_result = shr;
            rv_isa_pkg::OP_SLT:   alu_result = rv_isa_pkg::word_t'(cmp_lt);
            rv_isa_pkg::OP_SLTU:  alu_result = rv_isa_pkg::word_t'(cmp_ltu);
            rv_isa_pkg::OP_XOR:   alu_result = req.rs1 ^ op_b;
            rv_isa_pkg::OP_OR:    alu_result = req.rs1 | op_b;
            rv_isa_pkg::OP_AND:   alu_result = req.rs1 & op_b;
            rv_isa_pkg::OP_LUI:   alu_result = req.imm;    // upper bits prepared by decode
            default:              alu_result = '0;         // branches and jumps
        endcase
    end

endmodule

// File: verilog/exec_branch.sv
/*
 * Branch and jump unit
 * - condition decode from opcode and compare flags
 * - target adder and link value
 */
`include "exec_macros.svh"

module exec_branch (
    exec_req_if.branch               req,
    input exec_pipe_pkg::cmp_flags_t flags,
    exec_ctrl_if.branch              ctrl
);

    rv_isa_pkg::word_t tgt_base;
    rv_isa_pkg::word_t insn_len;

    // ====================
    // condition
    // ====================
    always_comb begin
        ctrl.is_ctrl = 1'b1;
        case (req.op)
            rv_isa_pkg::OP_BEQ:  ctrl.taken = flags.eq;
            rv_isa_pkg::OP_BNE:  ctrl.taken = ~flags.eq;
            rv_isa_pkg::OP_BLT:  ctrl.taken = flags.lt;
            rv_isa_pkg::OP_BGE:  ctrl.taken = ~flags.lt;
            rv_isa_pkg::OP_BLTU: ctrl.taken = flags.ltu;
            rv_isa_pkg::OP_BGEU: ctrl.taken = ~flags.ltu;
            rv_isa_pkg::OP_JAL,
            rv_isa_pkg::OP_JALR: ctrl.taken = 1'b1;    // unconditional
            default: begin
                ctrl.is_ctrl = 1'b0;
                ctrl.taken   = 1'b0;
            end
        endcase
    end

    // ====================
    // target and link
    // ====================
    // c.jalr comes in with imm of zero, so it lands on rs1 here too
    assign tgt_base    = (req.op == rv_isa_pkg::OP_JALR) ? req.rs1 : req.pc;
    assign ctrl.target = tgt_base + req.imm;

    assign insn_len  = req.ins_c ? rv_isa_pkg::word_t'(`INSN_LEN_COMP)
                                 : rv_isa_pkg::word_t'(`INSN_LEN_FULL);
    assign ctrl.link = req.pc + insn_len;    // return address

endmodule

// File: verilog/exec_retire.sv
/*
 * Execute retire
 * - final x[rd] select
 * - jump gating and the output register
 */
module exec_retire (
    input  logic              clk,
    input  logic              arst_n,
    exec_req_if.retire        req,
    input  rv_isa_pkg::word_t alu_result,
    exec_ctrl_if.retire       ctrl,
    output logic              valid_out,
    output rv_isa_pkg::word_t rd_value,
    output logic              jump_en,
    output rv_isa_pkg::word_t jump_addr
);

    rv_isa_pkg::word_t rd_next;
    logic              jump_next;

    // jumps write the link, branches write nothing
    always_comb begin
        if (ctrl.is_ctrl) begin
            if (req.op == rv_isa_pkg::OP_JAL || req.op == rv_isa_pkg::OP_JALR) begin
                rd_next = ctrl.link;
            end else begin
                rd_next = '0;
            end
        end else begin
            rd_next = alu_result;
        end
    end

    assign jump_next = req.valid & ctrl.taken;

    // ====================
    // output register
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
            rd_value  <= '0;
            jump_en   <= 1'b0;
            jump_addr <= '0;
        end else begin
            valid_out <= req.valid;
            rd_value  <= req.valid ? rd_next : '0;    // bubble shows zero
            jump_en   <= jump_next;
            jump_addr <= jump_next ? ctrl.target : '0;
        end
    end

endmodule

// File: verilog/exec_stage.sv
/*
 * Execute stage top level
 * - plain ports into the request interface
 * - ALU, branch unit and retire register
 */
module exec_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 valid_in,
    input  rv_isa_pkg::exec_op_e op,
    input  logic                 use_imm,
    input  logic                 ins_c,
    input  rv_isa_pkg::word_t    rs1,
    input  rv_isa_pkg::word_t    rs2,
    input  rv_isa_pkg::word_t    imm,
    input  rv_isa_pkg::word_t    pc,
    output logic                 valid_out,
    output rv_isa_pkg::word_t    rd_value,
    output logic                 jump_en,
    output rv_isa_pkg::word_t    jump_addr
);

    exec_req_if  req_if ();
    exec_ctrl_if ctrl_if ();

    rv_isa_pkg::word_t         alu_result;
    exec_pipe_pkg::cmp_flags_t flags;

    // ====================
    // request wiring
    // ====================
    assign req_if.valid   = valid_in;
    assign req_if.op      = op;
    assign req_if.use_imm = use_imm;
    assign req_if.ins_c   = ins_c;
    assign req_if.rs1     = rs1;
    assign req_if.rs2     = rs2;
    assign req_if.imm     = imm;
    assign req_if.pc      = pc;

    exec_alu u_alu (
        .req        (req_if.alu),
        .alu_result (alu_result),
        .flags      (flags)
    );

    exec_branch u_branch (
        .req   (req_if.branch),
        .flags (flags),
        .ctrl  (ctrl_if.branch)
    );

    exec_retire u_retire (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req_if.retire),
        .alu_result (alu_result),
        .ctrl       (ctrl_if.retire),
        .valid_out  (valid_out),
        .rd_value   (rd_value),
        .jump_en    (jump_en),
        .jump_addr  (jump_addr)
    );

endmodule

// File: sim/exec_stage_assert.sv
/*
 * Output assertions for the execute stage
 * - jump only with a valid result
 * - jump address zero when no jump
 * - outputs cleared coming out of reset
 * - count of failed assertions
 */
module exec_stage_assert (
    input logic              clk,
    input logic              arst_n,
    input logic              valid_out,
    input logic              jump_en,
    input rv_isa_pkg::word_t jump_addr
);

    int n_fail = 0;    // failed assertion count

    a_jump_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        jump_en |-> valid_out)
        else begin
            n_fail++;
            $error("jump_en high while valid_out low");
        end

    a_addr_zero: assert property (@(posedge clk) disable iff (!arst_n)
        !jump_en |-> (jump_addr == '0))
        else begin
            n_fail++;
            $error("jump_addr nonzero without jump_en");
        end

    // first edge with reset released still shows reset values
    a_reset_clear: assert property (@(posedge clk) $rose(arst_n) |-> (!valid_out && !jump_en))
        else begin
            n_fail++;
            $error("outputs not cleared after reset");
        end

endmodule

// File: sim/exec_stage_tb.sv
/*
 * Execute stage testbench
 * - clock, reset, directed table and LFSR random rounds
 * - reference model, output checks and verdict
 */
module exec_stage_tb;

    localparam int N_ROWS = 29;
    localparam int N_RAND = 300;

    typedef struct {
        logic                 v;
        rv_isa_pkg::exec_op_e op;
        logic                 ui;
        logic                 c;
        rv_isa_pkg::word_t    rs1, rs2, imm, pc;
        rv_isa_pkg::word_t    e_rd;
        logic                 e_j;
        rv_isa_pkg::word_t    e_a;
    } row_t;

    logic                 clk, arst_n, valid_in, use_imm, ins_c;
    rv_isa_pkg::exec_op_e op;
    rv_isa_pkg::word_t    rs1, rs2, imm, pc;
    logic                 valid_out, jump_en;
    rv_isa_pkg::word_t    rd_value, jump_addr;

    row_t        tbl [N_ROWS];
    int          n_fill = 0;
    int          n_errors = 0;
    int          n_checks = 0;
    logic [31:0] lfsr = 32'd22;
    logic        p_have = 1'b0;
    row_t        p_row;

    exec_stage DUT (.*);

    bind exec_stage exec_stage_assert u_assert (
        .clk(clk), .arst_n(arst_n), .valid_out(valid_out),
        .jump_en(jump_en), .jump_addr(jump_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog sized from the test length
    initial begin
        #((N_ROWS + N_RAND + 20) * 8);
        $display("timeout: run did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);    // galois step
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // expected results from the RV32I rules
    function automatic row_t model(input row_t r);
        rv_isa_pkg::word_t b;
        rv_isa_pkg::word_t lnk;
        logic              cond;
        b   = r.ui ? r.imm : r.rs2;
        lnk = r.pc + (r.c ? 32'd2 : 32'd4);
        r.e_rd = '0;
        r.e_j  = 1'b0;
        r.e_a  = '0;
        cond   = 1'b0;
        case (r.op)
            rv_isa_pkg::OP_ADD:   r.e_rd = r.rs1 + b;
            rv_isa_pkg::OP_SUB:   r.e_rd = r.rs1 - b;
            rv_isa_pkg::OP_SLL:   r.e_rd = r.rs1 << b[4:0];
            rv_isa_pkg::OP_SLT:   r.e_rd = {31'd0, $signed(r.rs1) < $signed(b)};
            rv_isa_pkg::OP_SLTU:  r.e_rd = {31'd0, r.rs1 < b};
            rv_isa_pkg::OP_XOR:   r.e_rd = r.rs1 ^ b;
            rv_isa_pkg::OP_SRL:   r.e_rd = r.rs1 >> b[4:0];
            rv_isa_pkg::OP_SRA:   r.e_rd = $signed(r.rs1) >>> b[4:0];
            rv_isa_pkg::OP_OR:    r.e_rd = r.rs1 | b;
            rv_isa_pkg::OP_AND:   r.e_rd = r.rs1 & b;
            rv_isa_pkg::OP_LUI:   r.e_rd = r.imm;
            rv_isa_pkg::OP_AUIPC: r.e_rd = r.pc + r.imm;
            rv_isa_pkg::OP_MEM:   r.e_rd = r.rs1 + r.imm;
            rv_isa_pkg::OP_JAL: begin
                r.e_rd = lnk;
                r.e_j  = 1'b1;
                r.e_a  = r.pc + r.imm;
            end
            rv_isa_pkg::OP_JALR: begin
                r.e_rd = lnk;
                r.e_j  = 1'b1;
                r.e_a  = r.rs1 + r.imm;
            end
            rv_isa_pkg::OP_BEQ:   cond = (r.rs1 == r.rs2);
            rv_isa_pkg::OP_BNE:   cond = (r.rs1 != r.rs2);
            rv_isa_pkg::OP_BLT:   cond = $signed(r.rs1) < $signed(r.rs2);
            rv_isa_pkg::OP_BGE:   cond = $signed(r.rs1) >= $signed(r.rs2);
            rv_isa_pkg::OP_BLTU:  cond = r.rs1 < r.rs2;
            rv_isa_pkg::OP_BGEU:  cond = r.rs1 >= r.rs2;
            default:              r.e_rd = '0;
        endcase
        if (cond) begin
            r.e_j = 1'b1;
            r.e_a = r.pc + r.imm;
        end
        if (!r.v) begin
            r.e_rd = '0;
            r.e_j  = 1'b0;
            r.e_a  = '0;
        end
        return r;
    endfunction

    task automatic add_row(input logic v, input rv_isa_pkg::exec_op_e o, input logic ui,
                           input logic c, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] im, input logic [31:0] p,
                           input logic [31:0] e_rd, input logic e_j, input logic [31:0] e_a);
        tbl[n_fill] = '{v, o, ui, c, a, b, im, p, e_rd, e_j, e_a};
        n_fill++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // drive one instruction, then check the one issued a cycle earlier
    task automatic issue(input row_t r);
        @(posedge clk);
        valid_in <= r.v;
        op       <= r.op;
        use_imm  <= r.ui;
        ins_c    <= r.c;
        rs1      <= r.rs1;
        rs2      <= r.rs2;
        imm      <= r.imm;
        pc       <= r.pc;
        @(negedge clk);
        if (p_have) begin
            check_value("valid_out", {31'd0, valid_out}, {31'd0, p_row.v});
            check_value("rd_value", rd_value, p_row.e_rd);
            check_value("jump_en", {31'd0, jump_en}, {31'd0, p_row.e_j});
            check_value("jump_addr", jump_addr, p_row.e_a);
        end
        p_have = 1'b1;
        p_row  = r;
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        row_t r;
        valid_in = 1'b0;
        op       = rv_isa_pkg::OP_ADD;
        use_imm  = 1'b0;
        ins_c    = 1'b0;
        rs1      = '0;
        rs2      = '0;
        imm      = '0;
        pc       = '0;
        arst_n   = 1'b0;

        //      v  op                     ui c  rs1           rs2           imm           pc
        add_row(1, rv_isa_pkg::OP_ADD,   0, 0, 32'h5,        32'h7,        32'h0,        32'h0,
                32'hC, 0, 0);
        add_row(1, rv_isa_pkg::OP_ADD,   1, 0, 32'h10,       32'h0,        32'hFFFFFFFF, 32'h0,
                32'hF, 0, 0);
        add_row(1, rv_isa_pkg::OP_SUB,   0, 0, 32'h5,        32'h7,        32'h0,        32'h0,
                32'hFFFFFFFE, 0, 0);
        add_row(1, rv_isa_pkg::OP_XOR,   0, 0, 32'hF0F0F0F0, 32'h0FF00FF0, 32'h0,        32'h0,
                32'hFF00FF00, 0, 0);
        add_row(1, rv_isa_pkg::OP_OR,    1, 0, 32'h00FF0000, 32'h0,        32'h0000FF00, 32'h0,
                32'h00FFFF00, 0, 0);
        add_row(1, rv_isa_pkg::OP_AND,   0, 0, 32'hFFFF0000, 32'h0F0F0F0F, 32'h0,        32'h0,
                32'h0F0F0000, 0, 0);
        add_row(1, rv_isa_pkg::OP_SLL,   0, 0, 32'h1,        32'h23,       32'h0,        32'h0,
                32'h8, 0, 0);    // amount 35 wraps to 3
        add_row(1, rv_isa_pkg::OP_SRL,   0, 0, 32'h80000000, 32'h4,        32'h0,        32'h0,
                32'h08000000, 0, 0);
        add_row(1, rv_isa_pkg::OP_SRA,   0, 0, 32'h80000000, 32'h4,        32'h0,        32'h0,
                32'hF8000000, 0, 0);
        add_row(1, rv_isa_pkg::OP_SRA,   1, 0, 32'hFFFFFF00, 32'h0,        32'h8,        32'h0,
                32'hFFFFFFFF, 0, 0);
        add_row(1, rv_isa_pkg::OP_SLT,   0, 0, 32'hFFFFFFFF, 32'h1,        32'h0,        32'h0,
                32'h1, 0, 0);
        add_row(1, rv_isa_pkg::OP_SLTU,  0, 0, 32'hFFFFFFFF, 32'h1,        32'h0,        32'h0,
                32'h0, 0, 0);
        add_row(1, rv_isa_pkg::OP_SLT,   1, 0, 32'h1,        32'h0,        32'hFFFFFFFF, 32'h0,
                32'h0, 0, 0);
        add_row(1, rv_isa_pkg::OP_SLTU,  1, 0, 32'h1,        32'h0,        32'hFFFFFFFF, 32'h0,
                32'h1, 0, 0);
        add_row(1, rv_isa_pkg::OP_LUI,   1, 0, 32'h0,        32'h0,        32'h12345000, 32'h0,
                32'h12345000, 0, 0);
        add_row(1, rv_isa_pkg::OP_AUIPC, 1, 0, 32'h0,        32'h0,        32'h2000,     32'h1000,
                32'h3000, 0, 0);
        add_row(1, rv_isa_pkg::OP_MEM,   1, 0, 32'h100,      32'h0,        32'hFFFFFFFC, 32'h0,
                32'hFC, 0, 0);
        add_row(1, rv_isa_pkg::OP_BEQ,   0, 0, 32'h3,        32'h3,        32'h20,       32'h400,
                32'h0, 1, 32'h420);
        add_row(1, rv_isa_pkg::OP_BEQ,   0, 0, 32'h3,        32'h4,        32'h20,       32'h400,
                32'h0, 0, 0);
        add_row(1, rv_isa_pkg::OP_BNE,   0, 0, 32'h3,        32'h4,        32'h20,       32'h400,
                32'h0, 1, 32'h420);
        add_row(1, rv_isa_pkg::OP_BLT,   0, 0, 32'hFFFFFFFF, 32'h1,        32'h20,       32'h400,
                32'h0, 1, 32'h420);
        add_row(1, rv_isa_pkg::OP_BGE,   0, 0, 32'hFFFFFFFF, 32'h1,        32'h20,       32'h400,
                32'h0, 0, 0);
        add_row(1, rv_isa_pkg::OP_BLTU,  0, 0, 32'hFFFFFFFF, 32'h1,        32'h20,       32'h400,
                32'h0, 0, 0);
        add_row(1, rv_isa_pkg::OP_BGEU,  0, 0, 32'hFFFFFFFF, 32'h1,        32'h20,       32'h400,
                32'h0, 1, 32'h420);
        add_row(1, rv_isa_pkg::OP_JAL,   0, 0, 32'h0,        32'h0,        32'h100,      32'h400,
                32'h404, 1, 32'h500);
        add_row(1, rv_isa_pkg::OP_JAL,   0, 1, 32'h0,        32'h0,        32'h100,      32'h400,
                32'h402, 1, 32'h500);
        add_row(1, rv_isa_pkg::OP_JALR,  0, 0, 32'h8000,     32'h0,        32'h10,       32'h400,
                32'h404, 1, 32'h8010);
        add_row(1, rv_isa_pkg::OP_JALR,  0, 1, 32'h9000,     32'h0,        32'h0,        32'h400,
                32'h402, 1, 32'h9000);    // c.jalr
        add_row(0, rv_isa_pkg::OP_ADD,   0, 0, 32'h5,        32'h7,        32'h0,        32'h0,
                32'h0, 0, 0);    // bubble

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("valid_out", {31'd0, valid_out}, 32'd0);
        check_value("rd_value", rd_value, 32'd0);
        check_value("jump_en", {31'd0, jump_en}, 32'd0);
        check_value("jump_addr", jump_addr, 32'd0);
        @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < N_ROWS; i++) begin
            issue(tbl[i]);
        end

        // ====================
        // random rounds
        // ====================
        for (int i = 0; i < N_RAND; i++) begin
            r.v   = (rand_bits(3) != 0);
            r.op  = rv_isa_pkg::exec_op_e'(5'(rand_bits(5) % 21));
            r.ui  = 1'(rand_bits(1));
            r.c   = 1'(rand_bits(1));
            r.rs1 = rand_bits(32);
            r.rs2 = (rand_bits(2) == 0) ? r.rs1 : rand_bits(32);    // hit equal operands
            r.imm = rand_bits(32);
            r.pc  = {31'(rand_bits(31)), 1'b0};
            if (r.op inside {rv_isa_pkg::OP_BEQ, rv_isa_pkg::OP_BNE, rv_isa_pkg::OP_BLT,
                             rv_isa_pkg::OP_BGE, rv_isa_pkg::OP_BLTU, rv_isa_pkg::OP_BGEU}) begin
                r.ui = 1'b0;    // branches compare registers
            end
            issue(model(r));
        end
        issue(tbl[N_ROWS-1]);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, DUT.u_assert.n_fail);
        if (n_errors == 0 && DUT.u_assert.n_fail == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: exec_stage.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/exec_pipe_pkg.sv
verilog/exec_if.sv
verilog/exec_alu.sv
verilog/exec_branch.sv
verilog/exec_retire.sv
verilog/exec_stage.sv
sim/exec_stage_assert.sv
sim/exec_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the execute stage testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wall -f exec_stage.f \
    --top-module exec_stage_tb -o exec_stage_sim > build.log 2>&1 \
    && ./obj_dir/exec_stage_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
